//--- backlightPwm.sv
// backlight dimming PWM, 256 cycle period
`timescale 1ns/1ps
`default_nettype none

module backlightPwm (
	input  logic       iSysClk,
	input  logic       reset,
	input  logic [7:0] duty,
	output logic       pwm
);

	logic [7:0] count;
	logic [7:0] dutyHold;

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			count    <= 8'd0;
			dutyHold <= 8'd0;
			pwm      <= 1'b0;
		end
		else
		begin
			count <= count + 1'b1;	// free running, wraps every 256
			if (count == 8'hff)
				dutyHold <= duty;	// take new duty only at period start
			pwm <= count < dutyHold;
		end
	end

endmodule

`default_nettype wire

//--- frameBufArbiter.sv
// frame buffer storage with a fixed priority port arbiter
// the write engine always wins, a read is served only in a cycle without a write
`timescale 1ns/1ps
`default_nettype none

module frameBufArbiter (
	input  logic                          iSysClk,
	input  videoTxPkg::memReq_t           wrReq,
	input  videoTxPkg::memReq_t           rdReq,
	output logic                          rdGrant,
	output logic [videoTxPkg::pixelW-1:0] rData
);
	import videoTxPkg::*;

	logic [pixelW-1:0] frameMem [1 << memAdrsW];	// single port, 4096 words
	memReq_t           sel;

	assign rdGrant = rdReq.req & ~wrReq.req;
	assign sel     = wrReq.req ? wrReq : rdReq;

	always_ff @(posedge iSysClk)
	begin
		if (sel.req)
		begin
			if (sel.we)
				frameMem[sel.adrs] <= sel.wData;
			else
				rData <= frameMem[sel.adrs];	// valid the cycle after grant
		end
	end

endmodule

`default_nettype wire

//--- frameReadDma.sv
// frame buffer read DMA
// prefetches pixels into a small FIFO and hands one out per active pixel
`timescale 1ns/1ps
`default_nettype none

module frameReadDma (
	input  logic                          iSysClk,
	input  logic                          reset,
	input  logic                          softRst,
	input  videoTxPkg::dmaCfg_t           dmaCfg,
	input  logic                          frameStart,
	input  logic                          activePixel,
	output videoTxPkg::memReq_t           memReq,
	input  logic                          grant,
	input  logic [videoTxPkg::pixelW-1:0] rData,
	output logic [videoTxPkg::pixelW-1:0] pixelOut,
	output logic                          pixelOutValid,
	output logic                          underrunSet
);
	import videoTxPkg::*;

	logic                           rst;
	logic [memAdrsW-1:0]            rdOfs;
	logic                           gotData;	// rData holds a granted word
	logic [$clog2(fifoDepth)-1:0]   wrPtr;
	logic [$clog2(fifoDepth)-1:0]   rdPtr;
	logic [$clog2(fifoDepth):0]     count;
	logic [pixelW-1:0]              fifoMem [fifoDepth];
	logic                           push;
	logic                           pop;
	logic                           empty;
	logic                           reqNow;

	assign rst         = reset | softRst;
	assign empty       = count == '0;
	assign pop         = activePixel & ~empty;
	assign push        = gotData & ~frameStart;	// words in flight at restart are dropped
	assign underrunSet = activePixel & empty;
	assign reqNow      = dmaCfg.dmaEn & ~frameStart & ((count + gotData) < fifoDepth);
	assign memReq      = '{req: reqNow, we: 1'b0, adrs: dmaCfg.rAdrs + rdOfs, wData: '0};

	always_ff @(posedge iSysClk)
	begin
		if (rst || frameStart)
		begin
			rdOfs   <= '0;
			gotData <= 1'b0;
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
		end
		else
		begin
			gotData <= grant;
			if (grant)
				rdOfs <= (rdOfs == dmaCfg.rLen - 1'b1) ? '0 : rdOfs + 1'b1;
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (push)
			fifoMem[wrPtr] <= rData;
	end

	// ------------------------------------------------
	// pixel output, zero on underrun
	// ------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			pixelOutValid <= 1'b0;
		else
			pixelOutValid <= activePixel;
		pixelOut <= empty ? '0 : fifoMem[rdPtr];
	end

endmodule

`default_nettype wire

//--- frameWriteDma.sv
// frame buffer write DMA
// stores strobed input pixels into a circular window of the frame buffer
`timescale 1ns/1ps
`default_nettype none

module frameWriteDma (
	input  logic                              iSysClk,
	input  logic                              reset,
	input  logic                              softRst,
	input  videoTxPkg::dmaCfg_t               dmaCfg,
	input  logic [videoTxPkg::pixelW-1:0]     pixelIn,
	input  logic                              pixelInValid,
	output videoTxPkg::memReq_t               memReq
);
	import videoTxPkg::*;

	logic                rst;
	logic                strobe;
	logic [memAdrsW-1:0] wrOfs;

	assign rst    = reset | softRst;
	assign strobe = dmaCfg.dmaEn & pixelInValid;

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			memReq.req <= 1'b0;
			wrOfs      <= '0;
		end
		else
		begin
			memReq.req <= strobe;	// one cycle write per strobe
			if (strobe)
				wrOfs <= (wrOfs == dmaCfg.wLen - 1'b1) ? '0 : wrOfs + 1'b1;
		end
		memReq.we    <= 1'b1;
		memReq.adrs  <= dmaCfg.wAdrs + wrOfs;
		memReq.wData <= pixelIn;
	end

endmodule

`default_nettype wire

//--- syncTimingGen.sv
// display sync timing generator
// line and frame counters decoded into syncs, active area and frame start
`timescale 1ns/1ps
`default_nettype none

module syncTimingGen (
	input  logic                     iSysClk,
	input  logic                     reset,
	input  logic                     softRst,
	input  videoTxPkg::videoTiming_t timing,
	output logic                     hSync,
	output logic                     vSync,
	output logic                     activePixel,
	output logic                     frameStart
);
	import videoTxPkg::*;

	logic                 rst;
	logic [hDisplayW:0]   hCount;
	logic [vDisplayW:0]   vCount;
	logic                 lineEnd;
	syncFlags_t           flagsNow;
	syncFlags_t           syncPipe [syncDelay];

	assign rst     = reset | softRst;
	assign lineEnd = hCount == timing.hSyncMax;

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			vCount <= (vCount == timing.vSyncMax) ? '0 : vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	assign flagsNow.hSync  = hCount >= timing.hSyncStart && hCount <= timing.hSyncEnd;
	assign flagsNow.vSync  = vCount >= timing.vSyncStart && vCount <= timing.vSyncEnd;
	assign flagsNow.active = hCount < timing.hDisplay && vCount < timing.vDisplay;

	// flags trail the counters so the read DMA can refill before the first pixel
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < syncDelay; i++)
				syncPipe[i] <= '0;
			frameStart <= 1'b0;
		end
		else
		begin
			syncPipe[0] <= flagsNow;
			for (int i = 1; i < syncDelay; i++)
				syncPipe[i] <= syncPipe[i-1];
			frameStart <= hCount == '0 && vCount == '0;
		end
	end

	assign hSync       = syncPipe[syncDelay-1].hSync;
	assign vSync       = syncPipe[syncDelay-1].vSync;
	assign activePixel = syncPipe[syncDelay-1].active;

endmodule

`default_nettype wire

//--- tbVideoTx.sv
// video transmitter testbench
// drives the CSR bus and pixel stream while bound assertions watch the outputs
`timescale 1ns/1ps
`default_nettype none

module tbVideoTx;
	import videoTxPkg::*;

	localparam int timeoutCycles = 2000;
	localparam int newHDisp  = 20;
	localparam int newHFront = 3;
	localparam int newHPulse = 4;
	localparam int newHBack  = 5;
	localparam int newVDisp  = 6;
	localparam int newVFront = 2;
	localparam int newVPulse = 3;
	localparam int newVBack  = 2;
	localparam int frameLen  = newHDisp * newVDisp;

	logic              iSysClk;
	logic              reset;
	csrBus_t           bus;
	logic [31:0]       rdData;
	logic              rdValid;
	logic [pixelW-1:0] pixelIn;
	logic              pixelInValid;
	logic              hSync;
	logic              vSync;
	logic [pixelW-1:0] pixelOut;
	logic              pixelOutValid;
	logic              displayRst;
	logic              pwm;
	int                errCount;
	logic [pixelW-1:0] frameWords [$];

	videoTx i_videoTx (
		.iSysClk(iSysClk), .reset(reset), .bus(bus), .rdData(rdData), .rdValid(rdValid),
		.pixelIn(pixelIn), .pixelInValid(pixelInValid), .hSync(hSync), .vSync(vSync),
		.pixelOut(pixelOut), .pixelOutValid(pixelOutValid), .displayRst(displayRst),
		.pwm(pwm));

	bind videoTx tbVideoTxSva i_videoTxSva (
		.iSysClk(iSysClk), .reset(reset), .bus(bus), .rdValid(rdValid), .hSync(hSync),
		.vSync(vSync), .pixelOutValid(pixelOutValid), .pwm(pwm),
		.displayRst(displayRst), .videoRst(videoRst), .timing(timing), .duty(duty));

	initial
	begin
		iSysClk = 1'b0;
		forever #10 iSysClk = ~iSysClk;
	end

	function automatic logic [31:0] pairOf(input int v, input int h);
		return {v[15:0], h[15:0]};
	endfunction

	task automatic stepCycles(input int n);
		repeat (n) @(posedge iSysClk);
		#1;	// inputs move just after the edge
	endtask

	task automatic busWrite(input logic [15:0] ofs, input logic [31:0] data);
		bus = '{wData: data, adrs: {blockAdrsMap, ofs}, wCke: 1'b1};
		stepCycles(1);
		bus = '0;	// idle address outside the block
	endtask

	task automatic busRead(input logic [23:0] adrs, input logic [31:0] echo,
		output logic [31:0] data, output logic seen);
		int waitCnt;
		bus = '{wData: echo, adrs: adrs, wCke: 1'b0};
		stepCycles(1);
		bus = '0;
		waitCnt = 0;
		while (!rdValid && waitCnt < 4)
		begin
			stepCycles(1);
			waitCnt++;
		end
		data = rdData;
		seen = rdValid;
	endtask

	task automatic checkRead(input string name, input logic [15:0] ofs, input logic [31:0] expVal);
		logic [31:0] got;
		logic        seen;
		busRead({blockAdrsMap, ofs}, 32'h0, got, seen);
		if (!seen)
		begin
			errCount++;
			$display("no rdValid after the read of %s", name);
		end
		else if (got !== expVal)
		begin
			errCount++;
			$display("FAIL rdData (%s): got %h expected %h", name, got, expVal);
		end
	endtask

	// start = display + front, end = start + pulse - 1, max = end + back
	task automatic checkSync(input int hDisp, hFr, hPul, hBk, vDisp, vFr, vPul, vBk);
		int hStart;
		int vStart;
		hStart = hDisp + hFr;
		vStart = vDisp + vFr;
		checkRead("syncStart", ofsSyncStart, pairOf(vStart, hStart));
		checkRead("syncEnd", ofsSyncEnd, pairOf(vStart + vPul - 1, hStart + hPul - 1));
		checkRead("syncMax", ofsSyncMax,
			pairOf(vStart + vPul - 1 + vBk, hStart + hPul - 1 + hBk));
	endtask

	task automatic checkPixels(input int count, input logic fromFrame);
		int got;
		int waitCnt;
		logic [pixelW-1:0] expVal;
		got = 0;
		waitCnt = 0;
		while (got < count && waitCnt < timeoutCycles)
		begin
			if (pixelOutValid)
			begin
				expVal = fromFrame ? frameWords[got] : '0;
				if (pixelOut !== expVal)
				begin
					errCount++;
					$display("FAIL pixelOut word %0d: got %h expected %h", got, pixelOut, expVal);
				end
				got++;
			end
			stepCycles(1);
			waitCnt++;
		end
		if (got < count)
		begin
			errCount++;
			$display("timeout, only %0d of %0d pixel words arrived", got, count);
		end
	endtask

	// ------------------------------------------------
	// stimulus
	// ------------------------------------------------
	initial
	begin
		logic [31:0]       got;
		logic              seen;
		logic [pixelW-1:0] word;
		void'($urandom(32'he694d3c5));
		errCount = 0;
		reset = 1'b1;
		bus = '0;
		pixelIn = '0;
		pixelInValid = 1'b0;
		stepCycles(5);
		reset = 1'b0;

		// register defaults
		checkRead("display", ofsDisplay, pairOf(vDisplayDef, hDisplayDef));
		checkRead("back", ofsBack, pairOf(vBackDef, hBackDef));
		checkRead("front", ofsFront, pairOf(vFrontDef, hFrontDef));
		checkRead("pulse", ofsPulse, pairOf(vPulseDef, hPulseDef));
		checkRead("ctrl", ofsCtrl, 32'h7);	// all soft resets held and no DMA
		checkRead("duty", ofsDuty, 32'h0);
		checkRead("wAdrs", ofsWAdrs, 32'h0);
		checkRead("rAdrs", ofsRAdrs, 32'h0);
		checkRead("wLen", ofsWLen, 32'(dmaWLenDef));
		checkRead("rLen", ofsRLen, 32'(dmaRLenDef));
		checkRead("status", ofsStatus, 32'h0);
		checkSync(hDisplayDef, hFrontDef, hPulseDef, hBackDef,
			vDisplayDef, vFrontDef, vPulseDef, vBackDef);

		// new timing while the generator is still held
		busWrite(ofsDisplay, pairOf(newVDisp, newHDisp));
		busWrite(ofsBack, pairOf(newVBack, newHBack));
		busWrite(ofsFront, pairOf(newVFront, newHFront));
		busWrite(ofsPulse, pairOf(newVPulse, newHPulse));
		stepCycles(2);	// derived values trail by a cycle
		checkSync(newHDisp, newHFront, newHPulse, newHBack,
			newVDisp, newVFront, newVPulse, newVBack);
		busRead({blockAdrsMap, 16'h0040}, 32'hc3a5_0f96, got, seen);
		if (!seen)
		begin
			errCount++;
			$display("no rdValid after the read of an undefined offset");
		end
		else if (got !== 32'hc3a5_0f96)
		begin
			errCount++;
			$display("FAIL rdData (echo): got %h expected %h", got, 32'hc3a5_0f96);
		end
		busRead({8'h05, 16'h0000}, 32'h0, got, seen);
		if (seen)
		begin
			errCount++;
			$display("rdValid came back for an address outside the block");
		end

		// frame path with both windows on the same buffer area
		busWrite(ofsDuty, 32'd77);
		busWrite(ofsWAdrs, 32'h100);
		busWrite(ofsRAdrs, 32'h100);
		busWrite(ofsWLen, frameLen);
		busWrite(ofsRLen, frameLen);
		busWrite(ofsCtrl, 32'h8);	// dmaEn with the soft resets released
		for (int k = 0; k < frameLen; k++)
		begin
			word = 16'($urandom);
			frameWords.push_back(word);
			pixelIn = word;
			pixelInValid = 1'b1;
			stepCycles(1);
			pixelInValid = 1'b0;	// idle cycle between strobes
			stepCycles(1);
		end
		stepCycles(4);
		busWrite(ofsCtrl, 32'ha);	// videoRst pulse restarts the frame
		busWrite(ofsCtrl, 32'h8);
		checkPixels(frameLen, 1'b1);

		// underrun with the DMA switched off
		busWrite(ofsStatus, 32'h1);
		busWrite(ofsCtrl, 32'h0);
		checkPixels(frameLen, 1'b0);
		checkRead("status", ofsStatus, 32'h1);
		busWrite(ofsCtrl, 32'h2);	// stop the display so no new underrun
		stepCycles(2);
		busWrite(ofsStatus, 32'h1);
		checkRead("status", ofsStatus, 32'h0);

		stepCycles(4);
		$display("errors: %0d in checks, %0d in assertions", errCount,
			i_videoTx.i_videoTxSva.failCount);
		if (errCount == 0 && i_videoTx.i_videoTxSva.failCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tbVideoTx_sva.sv
// video transmitter bound checks
// read strobe, reset state, sync and PWM timing
`timescale 1ns/1ps
`default_nettype none

module tbVideoTxSva (
	input logic                          iSysClk,
	input logic                          reset,
	input videoTxPkg::csrBus_t           bus,
	input logic                          rdValid,
	input logic                          hSync,
	input logic                          vSync,
	input logic                          pixelOutValid,
	input logic                          pwm,
	input logic                          displayRst,
	input logic                          videoRst,
	input videoTxPkg::videoTiming_t      timing,
	input logic [7:0]                    duty
);
	import videoTxPkg::*;

	int          failCount;
	logic        vidRst;
	logic        hSyncQ;
	logic        vSyncQ;
	logic        hSeen;
	logic [15:0] hPeriod;
	logic [15:0] hHigh;
	logic [19:0] vHigh;
	logic        pwmQ;
	logic        pwmSeen;
	logic [8:0]  pwmPeriod;
	logic [8:0]  pwmHigh;
	logic [7:0]  dutyQ;
	logic [9:0]  dutyAge;

	initial failCount = 0;

	assign vidRst = reset | videoRst;

	// ------------------------------------------------
	// edge to edge counters
	// ------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (vidRst)
		begin
			hSyncQ  <= 1'b0;
			vSyncQ  <= 1'b0;
			hSeen   <= 1'b0;
			hPeriod <= '0;
			hHigh   <= '0;
			vHigh   <= '0;
		end
		else
		begin
			hSyncQ <= hSync;
			vSyncQ <= vSync;
			if (hSync && !hSyncQ)
			begin
				hPeriod <= 16'd1;	// rising edge opens a new line
				hSeen   <= 1'b1;
			end
			else
				hPeriod <= hPeriod + 1'b1;
			if (hSync)
				hHigh <= hSyncQ ? hHigh + 1'b1 : 16'd1;
			if (vSync)
				vHigh <= vSyncQ ? vHigh + 1'b1 : 20'd1;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			pwmQ      <= 1'b0;
			pwmSeen   <= 1'b0;
			pwmPeriod <= '0;
			pwmHigh   <= '0;
			dutyQ     <= '0;
			dutyAge   <= '0;
		end
		else
		begin
			pwmQ  <= pwm;
			dutyQ <= duty;
			if (duty != dutyQ)
				dutyAge <= '0;
			else if (dutyAge != '1)
				dutyAge <= dutyAge + 1'b1;	// saturates
			if (pwm && !pwmQ)
			begin
				pwmPeriod <= 9'd1;
				pwmSeen   <= 1'b1;
			end
			else
				pwmPeriod <= pwmPeriod + 1'b1;
			if (pwm)
				pwmHigh <= pwmQ ? pwmHigh + 1'b1 : 9'd1;
		end
	end

	// ------------------------------------------------
	// properties
	// ------------------------------------------------
	a_rdValidHit: assert property (@(posedge iSysClk) disable iff (reset)
		bus.adrs[23:16] == blockAdrsMap |=> rdValid)
		else
		begin
			failCount++;
			$error("rdValid missing after a block access");
		end

	a_rdValidMiss: assert property (@(posedge iSysClk) disable iff (reset)
		bus.adrs[23:16] != blockAdrsMap |=> !rdValid)
		else
		begin
			failCount++;
			$error("rdValid after an access outside the block");
		end

	// outputs settle to their idle state under reset
	a_resetState: assert property (@(posedge iSysClk)
		reset |=> !rdValid && !hSync && !vSync && !pixelOutValid && !pwm && displayRst)
		else
		begin
			failCount++;
			$error("output not in reset state");
		end

	a_hPeriod: assert property (@(posedge iSysClk) disable iff (vidRst)
		hSync && !hSyncQ && hSeen |-> hPeriod == timing.hSyncMax + 1)
		else
		begin
			failCount++;
			$error("FAIL hSync period: got %h expected %h", $sampled(hPeriod),
				$sampled(timing.hSyncMax) + 16'd1);
		end

	a_hHigh: assert property (@(posedge iSysClk) disable iff (vidRst)
		!hSync && hSyncQ |-> hHigh == timing.hSyncEnd - timing.hSyncStart + 1)
		else
		begin
			failCount++;
			$error("FAIL hSync high time: got %h expected %h", $sampled(hHigh),
				$sampled(timing.hSyncEnd) - $sampled(timing.hSyncStart) + 16'd1);
		end

	a_vHigh: assert property (@(posedge iSysClk) disable iff (vidRst)
		!vSync && vSyncQ |->
		vHigh == (timing.vSyncEnd - timing.vSyncStart + 1) * (timing.hSyncMax + 1))
		else
		begin
			failCount++;
			$error("FAIL vSync high time: got %h expected %h", $sampled(vHigh),
				($sampled(timing.vSyncEnd) - $sampled(timing.vSyncStart) + 20'd1) *
				($sampled(timing.hSyncMax) + 20'd1));
		end

	a_pwmPeriod: assert property (@(posedge iSysClk) disable iff (reset)
		pwm && !pwmQ && pwmSeen |-> pwmPeriod == 256)
		else
		begin
			failCount++;
			$error("FAIL pwm period: got %h expected %h", $sampled(pwmPeriod), 9'd256);
		end

	a_pwmHigh: assert property (@(posedge iSysClk) disable iff (reset)
		!pwm && pwmQ && dutyAge >= 512 |-> pwmHigh == duty)
		else
		begin
			failCount++;
			$error("FAIL pwm high time: got %h expected %h", $sampled(pwmHigh),
				$sampled(duty));
		end

endmodule

`default_nettype wire

//--- videoTx.f
videoTxPkg.sv
videoTxCsr.sv
syncTimingGen.sv
backlightPwm.sv
frameWriteDma.sv
frameReadDma.sv
frameBufArbiter.sv
videoTx.sv
tbVideoTx_sva.sv
tbVideoTx.sv

//--- videoTx.sv
// video transmitter top
// CSR block, timing generator, backlight PWM and the two frame buffer DMA engines
`timescale 1ns/1ps
`default_nettype none

module videoTx (
	input  logic                          iSysClk,
	input  logic                          reset,
	input  videoTxPkg::csrBus_t           bus,
	output logic [31:0]                   rdData,
	output logic                          rdValid,
	input  logic [videoTxPkg::pixelW-1:0] pixelIn,
	input  logic                          pixelInValid,
	output logic                          hSync,
	output logic                          vSync,
	output logic [videoTxPkg::pixelW-1:0] pixelOut,
	output logic                          pixelOutValid,
	output logic                          displayRst,
	output logic                          pwm
);
	import videoTxPkg::*;

	videoTiming_t      timing;
	dmaCfg_t           dmaCfg;
	logic [7:0]        duty;
	logic              systemRst;
	logic              videoRst;
	logic              underrunSet;
	logic              activePixel;
	logic              frameStart;
	memReq_t           wrReq;
	memReq_t           rdReq;
	logic              rdGrant;
	logic [pixelW-1:0] memRData;

	videoTxCsr i_videoTxCsr (
		.iSysClk(iSysClk), .reset(reset), .bus(bus), .rdData(rdData), .rdValid(rdValid),
		.timing(timing), .dmaCfg(dmaCfg), .duty(duty), .systemRst(systemRst),
		.videoRst(videoRst), .displayRst(displayRst), .underrunSet(underrunSet));

	syncTimingGen i_syncTimingGen (
		.iSysClk(iSysClk), .reset(reset), .softRst(videoRst), .timing(timing),
		.hSync(hSync), .vSync(vSync), .activePixel(activePixel), .frameStart(frameStart));

	backlightPwm i_backlightPwm (
		.iSysClk(iSysClk), .reset(reset), .duty(duty), .pwm(pwm));

	frameWriteDma i_frameWriteDma (
		.iSysClk(iSysClk), .reset(reset), .softRst(systemRst), .dmaCfg(dmaCfg),
		.pixelIn(pixelIn), .pixelInValid(pixelInValid), .memReq(wrReq));

	frameReadDma i_frameReadDma (
		.iSysClk(iSysClk), .reset(reset), .softRst(systemRst), .dmaCfg(dmaCfg),
		.frameStart(frameStart), .activePixel(activePixel), .memReq(rdReq),
		.grant(rdGrant), .rData(memRData), .pixelOut(pixelOut),
		.pixelOutValid(pixelOutValid), .underrunSet(underrunSet));

	frameBufArbiter i_frameBufArbiter (
		.iSysClk(iSysClk), .wrReq(wrReq), .rdReq(rdReq), .rdGrant(rdGrant),
		.rData(memRData));

endmodule

`default_nettype wire

//--- videoTxCsr.sv
// video transmitter control and status registers
// decodes host writes, derives the sync points and serves block reads
`timescale 1ns/1ps
`default_nettype none

module videoTxCsr (
	input  logic                     iSysClk,
	input  logic                     reset,
	input  videoTxPkg::csrBus_t      bus,
	output logic [31:0]              rdData,
	output logic                     rdValid,
	output videoTxPkg::videoTiming_t timing,
	output videoTxPkg::dmaCfg_t      dmaCfg,
	output logic [7:0]               duty,
	output logic                     systemRst,
	output logic                     videoRst,
	output logic                     displayRst,
	input  logic                     underrunSet
);
	import videoTxPkg::*;

	logic [hDisplayW-1:0] hDisplay;
	logic [porchW-1:0]    hFront;
	logic [porchW-1:0]    hPulse;
	logic [porchW-1:0]    hBack;
	logic [vDisplayW-1:0] vDisplay;
	logic [vPorchW-1:0]   vFront;
	logic [vPorchW-1:0]   vPulse;
	logic [vPorchW-1:0]   vBack;
	logic                 dmaEn;
	logic [memAdrsW-1:0]  wAdrs;
	logic [memAdrsW-1:0]  rAdrs;
	logic [memAdrsW-1:0]  wLen;
	logic [memAdrsW-1:0]  rLen;
	logic                 underrun;
	logic [hDisplayW:0]   hSyncStart;
	logic [hDisplayW:0]   hSyncEnd;
	logic [hDisplayW:0]   hSyncMax;
	logic [vDisplayW:0]   vSyncStart;
	logic [vDisplayW:0]   vSyncEnd;
	logic [vDisplayW:0]   vSyncMax;
	logic                 blockHit;
	logic                 wrEn;
	logic [15:0]          offset;
	csrWord_u             wordIn;
	csrWord_u             rdWord;

	function automatic csrWord_u pairWord(input logic [15:0] v, input logic [15:0] h);
		pairWord.halfPair.v = v;
		pairWord.halfPair.h = h;
	endfunction

	assign blockHit = bus.adrs[busAdrsW-1:busAdrsW-8] == blockAdrsMap;
	assign wrEn     = bus.wCke & blockHit;
	assign offset   = bus.adrs[15:0];
	assign wordIn   = bus.wData;

	// ------------------------------------------------
	// register writes
	// ------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			hDisplay   <= hDisplayDef;
			hFront     <= hFrontDef;
			hPulse     <= hPulseDef;
			hBack      <= hBackDef;
			vDisplay   <= vDisplayDef;
			vFront     <= vFrontDef;
			vPulse     <= vPulseDef;
			vBack      <= vBackDef;
			systemRst  <= 1'b1;	// soft resets held until released by host
			videoRst   <= 1'b1;
			displayRst <= 1'b1;
			dmaEn      <= 1'b0;
			duty       <= 8'd0;
			wAdrs      <= '0;
			rAdrs      <= '0;
			wLen       <= dmaWLenDef;
			rLen       <= dmaRLenDef;
		end
		else if (wrEn)
		begin
			case (offset)
				ofsDisplay:
				begin
					vDisplay <= wordIn.halfPair.v[vDisplayW-1:0];
					hDisplay <= wordIn.halfPair.h[hDisplayW-1:0];
				end
				ofsBack:
				begin
					vBack <= wordIn.halfPair.v[vPorchW-1:0];
					hBack <= wordIn.halfPair.h[porchW-1:0];
				end
				ofsFront:
				begin
					vFront <= wordIn.halfPair.v[vPorchW-1:0];
					hFront <= wordIn.halfPair.h[porchW-1:0];
				end
				ofsPulse:
				begin
					vPulse <= wordIn.halfPair.v[vPorchW-1:0];
					hPulse <= wordIn.halfPair.h[porchW-1:0];
				end
				ofsCtrl:
				begin
					systemRst  <= wordIn.ctrlFlags.systemRst;
					videoRst   <= wordIn.ctrlFlags.videoRst;
					displayRst <= wordIn.ctrlFlags.displayRst;
					dmaEn      <= wordIn.ctrlFlags.dmaEn;
				end
				ofsDuty:  duty  <= bus.wData[7:0];
				ofsWAdrs: wAdrs <= bus.wData[memAdrsW-1:0];
				ofsRAdrs: rAdrs <= bus.wData[memAdrsW-1:0];
				ofsWLen:  wLen  <= bus.wData[memAdrsW-1:0];
				ofsRLen:  rLen  <= bus.wData[memAdrsW-1:0];
				default: ;
			endcase
		end
	end

	// sticky underrun, a new event wins over the clear
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			underrun <= 1'b0;
		else if (underrunSet)
			underrun <= 1'b1;
		else if (wrEn && offset == ofsStatus && bus.wData[0])
			underrun <= 1'b0;
	end

	// derived sync points, one cycle behind the fields
	always_ff @(posedge iSysClk)
	begin
		hSyncStart <= hDisplay + hFront;
		hSyncEnd   <= hDisplay + hFront + hPulse - 1'b1;
		hSyncMax   <= hDisplay + hFront + hPulse + hBack - 1'b1;
		vSyncStart <= vDisplay + vFront;
		vSyncEnd   <= vDisplay + vFront + vPulse - 1'b1;
		vSyncMax   <= vDisplay + vFront + vPulse + vBack - 1'b1;
	end

	assign timing = '{hDisplay: hDisplay, vDisplay: vDisplay,
		hSyncStart: hSyncStart, hSyncEnd: hSyncEnd, hSyncMax: hSyncMax,
		vSyncStart: vSyncStart, vSyncEnd: vSyncEnd, vSyncMax: vSyncMax};
	assign dmaCfg = '{dmaEn: dmaEn, wAdrs: wAdrs, rAdrs: rAdrs, wLen: wLen, rLen: rLen};

	// ------------------------------------------------
	// read mux
	// ------------------------------------------------
	always_comb
	begin
		case (offset)
			ofsDisplay:   rdWord = pairWord(vDisplay, hDisplay);
			ofsBack:      rdWord = pairWord(vBack, hBack);
			ofsFront:     rdWord = pairWord(vFront, hFront);
			ofsPulse:     rdWord = pairWord(vPulse, hPulse);
			ofsCtrl:      rdWord = {28'd0, dmaEn, displayRst, videoRst, systemRst};
			ofsDuty:      rdWord = {24'd0, duty};
			ofsWAdrs:     rdWord = 32'(wAdrs);
			ofsRAdrs:     rdWord = 32'(rAdrs);
			ofsWLen:      rdWord = 32'(wLen);
			ofsRLen:      rdWord = 32'(rLen);
			ofsStatus:    rdWord = {31'd0, underrun};
			ofsSyncStart: rdWord = pairWord(vSyncStart, hSyncStart);
			ofsSyncEnd:   rdWord = pairWord(vSyncEnd, hSyncEnd);
			ofsSyncMax:   rdWord = pairWord(vSyncMax, hSyncMax);
			default:      rdWord = bus.wData;	// echo of the bus word
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		rdData <= rdWord;
		if (reset)
			rdValid <= 1'b0;
		else
			rdValid <= blockHit;
	end

endmodule

`default_nettype wire

//--- videoTxPkg.sv
// video transmitter shared definitions
// bus and register map constants, reset defaults, and the structs between blocks
`default_nettype none

package videoTxPkg;

	// ------------------------------------------------
	// bus and memory geometry
	// ------------------------------------------------
	localparam logic [7:0] blockAdrsMap = 8'h04;	// block select in adrs[23:16]
	localparam int busAdrsW  = 24;
	localparam int hDisplayW = 11;
	localparam int vDisplayW = 11;
	localparam int porchW    = 7;	// horizontal porch and pulse
	localparam int vPorchW   = 5;	// vertical porch and pulse
	localparam int memAdrsW  = 12;	// 4096 word frame buffer
	localparam int pixelW    = 16;
	localparam int fifoDepth = 4;

	// counter to sync output latency, frameStart leads activePixel by syncDelay-1
	localparam int syncDelay = 6;

	// ------------------------------------------------
	// reset defaults
	// ------------------------------------------------
	localparam logic [hDisplayW-1:0] hDisplayDef = 16;
	localparam logic [porchW-1:0]    hFrontDef   = 2;
	localparam logic [porchW-1:0]    hPulseDef   = 3;
	localparam logic [porchW-1:0]    hBackDef    = 4;
	localparam logic [vDisplayW-1:0] vDisplayDef = 8;
	localparam logic [vPorchW-1:0]   vFrontDef   = 1;
	localparam logic [vPorchW-1:0]   vPulseDef   = 2;
	localparam logic [vPorchW-1:0]   vBackDef    = 1;
	localparam logic [memAdrsW-1:0]  dmaWLenDef  = 128;
	localparam logic [memAdrsW-1:0]  dmaRLenDef  = 128;

	// ------------------------------------------------
	// register offsets inside the block
	// ------------------------------------------------
	localparam logic [15:0] ofsDisplay   = 16'h0000;
	localparam logic [15:0] ofsBack      = 16'h0004;
	localparam logic [15:0] ofsFront     = 16'h0008;
	localparam logic [15:0] ofsPulse     = 16'h000c;
	localparam logic [15:0] ofsCtrl      = 16'h0010;
	localparam logic [15:0] ofsDuty      = 16'h0014;
	localparam logic [15:0] ofsWAdrs     = 16'h0018;
	localparam logic [15:0] ofsRAdrs     = 16'h001c;
	localparam logic [15:0] ofsWLen      = 16'h0020;
	localparam logic [15:0] ofsRLen      = 16'h0024;
	localparam logic [15:0] ofsStatus    = 16'h0028;
	localparam logic [15:0] ofsSyncStart = 16'h0080;
	localparam logic [15:0] ofsSyncEnd   = 16'h0084;
	localparam logic [15:0] ofsSyncMax   = 16'h0088;

	typedef struct packed {
		logic [31:0]         wData;
		logic [busAdrsW-1:0] adrs;
		logic                wCke;
	} csrBus_t;

	typedef struct packed {
		logic [15:0] v;
		logic [15:0] h;
	} halfPair_t;

	typedef struct packed {
		logic [27:0] spare;
		logic        dmaEn;
		logic        displayRst;
		logic        videoRst;
		logic        systemRst;
	} ctrlFlags_t;

	// one CSR word, seen as a v/h pair or as control flags
	typedef union packed {
		halfPair_t  halfPair;
		ctrlFlags_t ctrlFlags;
	} csrWord_u;

	typedef struct packed {
		logic [hDisplayW-1:0] hDisplay;
		logic [vDisplayW-1:0] vDisplay;
		logic [hDisplayW:0]   hSyncStart;
		logic [hDisplayW:0]   hSyncEnd;
		logic [hDisplayW:0]   hSyncMax;
		logic [vDisplayW:0]   vSyncStart;
		logic [vDisplayW:0]   vSyncEnd;
		logic [vDisplayW:0]   vSyncMax;
	} videoTiming_t;

	typedef struct packed {
		logic                dmaEn;
		logic [memAdrsW-1:0] wAdrs;
		logic [memAdrsW-1:0] rAdrs;
		logic [memAdrsW-1:0] wLen;
		logic [memAdrsW-1:0] rLen;
	} dmaCfg_t;

	typedef struct packed {
		logic                req;
		logic                we;
		logic [memAdrsW-1:0] adrs;
		logic [pixelW-1:0]   wData;
	} memReq_t;

	typedef struct packed {
		logic hSync;
		logic vSync;
		logic active;
	} syncFlags_t;

endpackage

`default_nettype wire
